/* logic/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// levels selectable from the menu, frame 0 is the menu itself
`define GAME_LEVELS 5

// stored frame size, one stored pixel per 4x4 screen block
`define GAME_FRAME_W 160
`define GAME_FRAME_H 120
`define GAME_FRAME_WORDS 19200

// visible screen derived from the frame size
`define GAME_SCREEN_W (`GAME_FRAME_W * 4)
`define GAME_SCREEN_H (`GAME_FRAME_H * 4)

`define GAME_ADDR_W 17
`define GAME_BEAM_W 10

// scan codes, bit 8 marks an E0 extended code
`define GAME_SC_RIGHT 9'h174
`define GAME_SC_LEFT 9'h16B
`define GAME_SC_UP 9'h175
`define GAME_SC_DOWN 9'h172
`define GAME_SC_ENTER 9'h05A
`define GAME_SC_ESC 9'h076

`endif

/* logic/key_pkg.sv */
`default_nettype none

package key_pkg;

    // one opcode per recognised key press
    // arrows fold into next/prev, so right and down
    // act the same, as do left and up
    typedef enum logic [2:0] {
        // no action this cycle
        act_none,
        // right or down arrow
        act_next,
        // left or up arrow
        act_prev,
        // select the highlighted level
        act_enter,
        // leave the running level
        act_escape
    } key_action_e;

endpackage

`default_nettype wire

/* logic/screen_pkg.sv */
`default_nettype none

package screen_pkg;

    // which screen is on the display
    typedef enum logic {
        // level select menu, frame 0
        scr_menu,
        // a level is running, frame = level
        scr_play
    } screen_e;

    // level number, valid range 1 to 5
    // also serves directly as the frame index in play
    typedef logic [2:0] level_t;

    // first selectable level, used at reset
    localparam level_t LEVEL_FIRST = 3'd1;

endpackage

`default_nettype wire

/* logic/key_action_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module key_action_decoder (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    key_valid,
    input  wire  [8:0]             key_code,
    input  wire                    key_release,
    output logic                   action_valid,
    output key_pkg::key_action_e   action
);

    // one held flag per recognised code
    // order: right, down, left, up, enter, esc
    logic [5:0]           key_hit;
    logic [5:0]           held;
    key_pkg::key_action_e code_action;
    logic                 press_ok;

    always_comb begin
        key_hit     = 6'b000000;
        code_action = key_pkg::act_none;
        case (key_code)
            `GAME_SC_RIGHT: begin
                key_hit[0]  = 1'b1;
                code_action = key_pkg::act_next;
            end
            `GAME_SC_DOWN: begin
                key_hit[1]  = 1'b1;
                code_action = key_pkg::act_next;
            end
            `GAME_SC_LEFT: begin
                key_hit[2]  = 1'b1;
                code_action = key_pkg::act_prev;
            end
            `GAME_SC_UP: begin
                key_hit[3]  = 1'b1;
                code_action = key_pkg::act_prev;
            end
            `GAME_SC_ENTER: begin
                key_hit[4]  = 1'b1;
                code_action = key_pkg::act_enter;
            end
            `GAME_SC_ESC: begin
                key_hit[5]  = 1'b1;
                code_action = key_pkg::act_escape;
            end
            default: ;
        endcase
    end

    // any held key blocks new presses, this covers typematic
    // repeats of the same key as well as a second key
    assign press_ok = key_valid && !key_release && (|key_hit) && !(|held);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held         <= 6'b000000;
            action_valid <= 1'b0;
        end else begin
            action_valid <= press_ok;
            if (key_valid) begin
                if (key_release) begin
                    held <= held & ~key_hit;
                end else begin
                    held <= held | key_hit;
                end
            end
        end
    end

    // only meaningful alongside action_valid
    always_ff @(posedge clk) begin
        action <= code_action;
    end

endmodule

`default_nettype wire

/* logic/level_select_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module level_select_fsm (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    action_valid,
    input  wire key_pkg::key_action_e action,
    input  wire                    level_clear,
    output screen_pkg::screen_e    screen,
    output screen_pkg::level_t     level
);

    localparam screen_pkg::level_t LEVEL_LAST = screen_pkg::level_t'(`GAME_LEVELS);

    screen_pkg::screen_e screen_d;
    screen_pkg::level_t  level_d;
    screen_pkg::level_t  level_up;
    screen_pkg::level_t  level_down;

    // saturating neighbours of the current level
    always_comb begin
        if (level < LEVEL_LAST) begin
            level_up = level + 3'd1;
        end else begin
            level_up = LEVEL_LAST;
        end
        if (level > screen_pkg::LEVEL_FIRST) begin
            level_down = level - 3'd1;
        end else begin
            level_down = screen_pkg::LEVEL_FIRST;
        end
    end

    always_comb begin
        screen_d = screen;
        level_d  = level;
        case (screen)
            screen_pkg::scr_menu: begin
                // level_clear has no meaning in the menu
                if (action_valid) begin
                    case (action)
                        key_pkg::act_next: begin
                            level_d = level_up;
                        end
                        key_pkg::act_prev: begin
                            level_d = level_down;
                        end
                        key_pkg::act_enter: begin
                            screen_d = screen_pkg::scr_play;
                        end
                        default: ;
                    endcase
                end
            end
            screen_pkg::scr_play: begin
                // clear beats any key in the same cycle
                if (level_clear) begin
                    screen_d = screen_pkg::scr_menu;
                    level_d  = level_up;
                end else if (action_valid && action == key_pkg::act_escape) begin
                    screen_d = screen_pkg::scr_menu;
                end
                // arrows and enter in play go to the game logic
            end
            default: begin
                screen_d = screen_pkg::scr_menu;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            screen <= screen_pkg::scr_menu;
            level  <= screen_pkg::LEVEL_FIRST;
        end else begin
            screen <= screen_d;
            level  <= level_d;
        end
    end

endmodule

`default_nettype wire

/* logic/pixel_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module pixel_addr_gen (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [`GAME_BEAM_W-1:0]   beam_h,
    input  wire  [`GAME_BEAM_W-1:0]   beam_v,
    input  wire screen_pkg::screen_e  screen,
    input  wire screen_pkg::level_t   level,
    output logic [`GAME_ADDR_W-1:0]   pixel_addr
);

    localparam int ADDR_W = `GAME_ADDR_W;
    localparam int BEAM_W = `GAME_BEAM_W;

    // last visible column and row
    localparam logic [BEAM_W-1:0] H_LAST = BEAM_W'(`GAME_SCREEN_W - 1);
    localparam logic [BEAM_W-1:0] V_LAST = BEAM_W'(`GAME_SCREEN_H - 1);

    screen_pkg::level_t  frame_idx;
    logic [BEAM_W-1:0]   h_clamp;
    logic [BEAM_W-1:0]   v_clamp;
    logic [BEAM_W-3:0]   col;
    logic [BEAM_W-3:0]   row;
    logic [ADDR_W-1:0]   frame_base;
    logic [ADDR_W-1:0]   row_base;

    // stage a registers
    logic [ADDR_W-1:0]   base_a;
    logic [BEAM_W-3:0]   col_a;

    // menu is frame 0, a level uses its own frame
    assign frame_idx = (screen == screen_pkg::scr_play) ? level : 3'd0;

    // off-screen beam maps to the edge pixel
    assign h_clamp = (beam_h > H_LAST) ? H_LAST : beam_h;
    assign v_clamp = (beam_v > V_LAST) ? V_LAST : beam_v;

    // 4x4 screen block per stored pixel
    assign col = h_clamp[BEAM_W-1:2];
    assign row = v_clamp[BEAM_W-1:2];

    assign frame_base = ADDR_W'(frame_idx) * ADDR_W'(`GAME_FRAME_WORDS);
    assign row_base   = ADDR_W'(row) * ADDR_W'(`GAME_FRAME_W);

    // stage a, frame and row offset plus the column
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base_a <= '0;
            col_a  <= '0;
        end else begin
            base_a <= frame_base + row_base;
            col_a  <= col;
        end
    end

    // stage b, final address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr <= base_a + ADDR_W'(col_a);
        end
    end

endmodule

`default_nettype wire

/* logic/map_switch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module map_switch_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       key_valid,
    input  wire  [8:0]                key_code,
    input  wire                       key_release,
    input  wire                       level_clear,
    input  wire  [`GAME_BEAM_W-1:0]   beam_h,
    input  wire  [`GAME_BEAM_W-1:0]   beam_v,
    output logic [`GAME_ADDR_W-1:0]   pixel_addr,
    output logic                      playing,
    output screen_pkg::level_t        level
);

    // decoder to fsm
    logic                 action_valid;
    key_pkg::key_action_e action;

    // fsm to address generator
    screen_pkg::screen_e  screen;

    key_action_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_release  (key_release),
        .action_valid (action_valid),
        .action       (action)
    );

    level_select_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .action_valid (action_valid),
        .action       (action),
        .level_clear  (level_clear),
        .screen       (screen),
        .level        (level)
    );

    pixel_addr_gen u_addr (
        .clk          (clk),
        .rst          (rst),
        .beam_h       (beam_h),
        .beam_v       (beam_v),
        .screen       (screen),
        .level        (level),
        .pixel_addr   (pixel_addr)
    );

    assign playing = (screen == screen_pkg::scr_play);

endmodule

`default_nettype wire

/* dv/tb_map_switch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module tb_map_switch;

    // cycles any single wait may take before giving up
    localparam int WAIT_LIMIT = 16;

    logic                    clk;
    logic                    rst;
    logic                    key_valid;
    logic [8:0]              key_code;
    logic                    key_release;
    logic                    level_clear;
    logic [`GAME_BEAM_W-1:0] beam_h;
    logic [`GAME_BEAM_W-1:0] beam_v;
    wire  [`GAME_ADDR_W-1:0] pixel_addr;
    wire                     playing;
    screen_pkg::level_t      level;

    logic [31:0] rng_state;
    int          cycle_cnt;
    int          last_event;
    // expected address and due cycle of each pending check
    int          exp_addr_q[$];
    int          due_q[$];

    map_switch_top u_map_switch_top (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .key_release (key_release),
        .level_clear (level_clear),
        .beam_h      (beam_h),
        .beam_v      (beam_v),
        .pixel_addr  (pixel_addr),
        .playing     (playing),
        .level       (level)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stop_run($sformatf("** Error at time %0t: %s expected %0d, got %0d",
                               $time, name, expected, actual));
        end
    endtask

    // inputs fall back to idle and the beam moves on every clock
    task automatic tick();
        @(posedge clk);
        cycle_cnt = cycle_cnt + 1;
        rng_state = xorshift(rng_state);
        key_valid   <= 1'b0;
        key_release <= 1'b0;
        level_clear <= 1'b0;
        beam_h      <= rng_state[`GAME_BEAM_W-1:0];
        beam_v      <= rng_state[16+`GAME_BEAM_W-1:16];
    endtask

    task automatic idle_gap();
        int n;
        rng_state = xorshift(rng_state);
        n = int'(rng_state[1:0]);
        repeat (n) tick();
    endtask

    // event at edge c reaches playing and level after edge c+2
    task automatic wait_settled();
        int guard;
        guard = 0;
        while (cycle_cnt < last_event + 2) begin
            tick();
            guard = guard + 1;
            if (guard > WAIT_LIMIT) begin
                stop_run("timeout while waiting for playing and level to settle");
            end
        end
        @(negedge clk);
    endtask

    task automatic drain_checks();
        int guard;
        guard = 0;
        while (due_q.size() > 0) begin
            tick();
            guard = guard + 1;
            if (guard > WAIT_LIMIT) begin
                stop_run("timeout while waiting for pending pixel address checks");
            end
        end
    endtask

    // address results are compared mid-cycle on the exact due cycle
    always @(negedge clk) begin
        if (due_q.size() > 0) begin
            if (due_q[0] == cycle_cnt) begin
                check_value("pixel_addr", exp_addr_q[0], int'(pixel_addr));
                void'(due_q.pop_front());
                void'(exp_addr_q.pop_front());
            end
        end
    end

    initial begin
        int               fd;
        int               n;
        int               a;
        int               b;
        int               c;
        logic             done;
        logic [7:0]       cmd;
        logic [7:0]       prev_cmd;
        logic [8*128-1:0] skip;
        rst         <= 1'b1;
        key_valid   <= 1'b0;
        key_code    <= 9'd0;
        key_release <= 1'b0;
        level_clear <= 1'b0;
        beam_h      <= '0;
        beam_v      <= '0;
        rng_state  = 32'd83069;
        cycle_cnt  = 0;
        last_event = 0;
        prev_cmd   = 8'd0;
        done       = 1'b0;
        fd = $fopen("dv/map_switch_tests.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open dv/map_switch_tests.txt");
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": begin
                        n = $fgets(skip, fd);
                    end
                    "K": begin
                        n = $fscanf(fd, "%h %d", a, b);
                        if (n != 2) begin
                            stop_run("malformed K command in the tests file");
                        end
                        idle_gap();
                        tick();
                        key_valid   <= 1'b1;
                        key_code    <= a[8:0];
                        key_release <= b[0];
                        last_event = cycle_cnt;
                    end
                    "C": begin
                        idle_gap();
                        tick();
                        level_clear <= 1'b1;
                        last_event = cycle_cnt;
                    end
                    "W": begin
                        n = $fscanf(fd, "%d", a);
                        if (n != 1) begin
                            stop_run("malformed W command in the tests file");
                        end
                        repeat (a) tick();
                    end
                    "S": begin
                        n = $fscanf(fd, "%d %d", a, b);
                        if (n != 2) begin
                            stop_run("malformed S command in the tests file");
                        end
                        wait_settled();
                        check_value("playing", a, int'(playing));
                        check_value("level", b, int'(level));
                    end
                    "P": begin
                        n = $fscanf(fd, "%d %d %d", a, b, c);
                        if (n != 3) begin
                            stop_run("malformed P command in the tests file");
                        end
                        // consecutive P lines go out on consecutive cycles
                        if (prev_cmd != "P") begin
                            idle_gap();
                        end
                        tick();
                        beam_h <= a[`GAME_BEAM_W-1:0];
                        beam_v <= b[`GAME_BEAM_W-1:0];
                        exp_addr_q.push_back(c);
                        due_q.push_back(cycle_cnt + 2);
                    end
                    default: begin
                        stop_run($sformatf("unknown command %c in the tests file", cmd));
                    end
                endcase
                prev_cmd = cmd;
            end
        end
        $fclose(fd);
        drain_checks();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/map_switch_tests.txt */
# one command per line, key codes in hex, all other numbers decimal
# K code release | C | W cycles | S playing level | P beam_h beam_v pixel_addr
S 0 1
P 8 4 162
K 16B 0
K 16B 1
S 0 1
K 174 0
K 174 1
K 172 0
K 172 1
S 0 3
K 174 0
K 174 0
K 174 1
S 0 4
K 172 0
K 175 0
K 172 1
K 175 1
K 01C 0
K 01C 1
S 0 5
K 174 0
K 174 1
S 0 5
K 175 0
K 175 1
K 16B 0
K 16B 1
S 0 3
K 05A 0
K 05A 1
S 1 3
P 8 4 57762
P 17 9 57924
K 174 0
K 174 1
S 1 3
K 076 0
K 076 1
S 0 3
P 8 4 162
C
W 3
S 0 3
K 05A 0
K 05A 1
S 1 3
C
S 0 4
K 05A 0
K 05A 1
S 1 4
P 636 476 95999
P 12 480 95843
C
S 0 5
K 05A 0
K 05A 1
S 1 5
P 0 0 96000
P 639 479 115199
P 1000 600 115199
P 4 479 115041
P 700 8 96479
C
S 0 5

/* tb.f */
+incdir+logic
logic/key_pkg.sv
logic/screen_pkg.sv
logic/key_action_decoder.sv
logic/level_select_fsm.sv
logic/pixel_addr_gen.sv
logic/map_switch_top.sv
dv/tb_map_switch.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing -f tb.f --top-module tb_map_switch --Mdir obj_dir -o sim_map_switch
	-./obj_dir/sim_map_switch > sim.log 2>&1
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall +incdir+logic \
		logic/key_pkg.sv logic/screen_pkg.sv \
		logic/key_action_decoder.sv logic/level_select_fsm.sv \
		logic/pixel_addr_gen.sv logic/map_switch_top.sv \
		--top-module map_switch_top

clean:
	rm -rf obj_dir sim.log
